// ==== hdl/delay_line.sv ====
`timescale 1ns/1ps

module delay_line
	import ks_pkg::*;
(
	input  logic                        clk,
	input  logic                        trig_reset,
	input  ks_step_t                    step,
	input  logic                        wr_en,
	input  logic [KS_ADDR_W-1:0]        wr_addr,
	input  logic signed [KS_DATA_W-1:0] wr_data,
	output ks_step_t                    step_q,
	output logic signed [KS_DATA_W-1:0] rd_data
);

	// one word per string slot
	logic signed [KS_DATA_W-1:0] mem [0:(2**KS_ADDR_W)-1];

	// write back of finished samples
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read only on issued steps
	always_ff @(posedge clk)
	begin
		if (step.valid)
		begin
			rd_data <= mem[step.addr];
		end
	end

	// step travels alongside its read word
	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			step_q <= '0;
		end
		else
		begin
			step_q <= step;
		end
	end

	// minimum length of 4 keeps the write back clear of the next read
	no_rw_collision: assert property (@(posedge clk) disable iff (trig_reset)
		!(wr_en && step.valid && (wr_addr == step.addr)));

endmodule

// ==== hdl/ks_control.sv ====
`timescale 1ns/1ps

module ks_control
	import ks_pkg::*;
(
	input  logic     clk,
	input  logic     trig_reset,
	input  logic     pluck,
	input  ks_cfg_t  cfg,
	input  logic     credit_return,
	output ks_step_t step
);

	ks_state_e state;

	logic pluck_q;
	logic pluck_edge;

	// clamped config and the copy held for the current note
	ks_cfg_t cfg_clamped;
	ks_cfg_t cfg_q;

	logic [KS_ADDR_W-1:0] ptr;
	logic                 ptr_last;
	logic [KS_ADDR_W-1:0] exc_cnt;

	logic [$clog2(KS_DRAIN_CYCLES+1)-1:0] drain_cnt;
	logic [$clog2(KS_CREDITS+1)-1:0]      credits;

	logic issue;

	assign pluck_edge = pluck & ~pluck_q;

	always_comb
	begin
		cfg_clamped = cfg;
		if (cfg.length < KS_MIN_LEN)
		begin
			cfg_clamped.length = KS_ADDR_W'(KS_MIN_LEN);
		end
	end

	// a step goes out only when the consumer has room for its sample
	assign issue = (credits != '0) && ((state == EXCITE) || (state == SUSTAIN));
	assign ptr_last = (ptr == cfg_q.length - 1'b1);

	always_comb
	begin
		step.valid       = issue;
		step.addr        = ptr;
		step.excite      = (state == EXCITE);
		step.decay_shift = cfg_q.decay_shift;
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			state     <= IDLE;
			pluck_q   <= 1'b0;
			cfg_q     <= '{length: KS_ADDR_W'(KS_MIN_LEN), decay_shift: 4'd0};
			drain_cnt <= '0;
			ptr       <= '0;
			exc_cnt   <= '0;
		end
		else
		begin
			pluck_q <= pluck;
			if (pluck_edge)
			begin
				// restart from any state while the drain lets old samples finish
				state     <= DRAIN;
				cfg_q     <= cfg_clamped;
				drain_cnt <= '0;
				ptr       <= '0;
				exc_cnt   <= '0;
			end
			else
			begin
				case (state)
					DRAIN:
					begin
						if (drain_cnt == KS_DRAIN_CYCLES - 1)
						begin
							state <= EXCITE;
						end
						else
						begin
							drain_cnt <= drain_cnt + 1'b1;
						end
					end
					EXCITE:
					begin
						if (issue)
						begin
							exc_cnt <= exc_cnt + 1'b1;
							// one full string of noise, then sustain
							if (exc_cnt == cfg_q.length - 1'b1)
							begin
								state <= SUSTAIN;
							end
						end
					end
					default:
					begin
					end
				endcase

				if (issue)
				begin
					ptr <= ptr_last ? '0 : ptr + 1'b1;
				end
			end
		end
	end

	// issue and return in the same cycle cancel out
	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			credits <= ($clog2(KS_CREDITS+1))'(KS_CREDITS);
		end
		else
		begin
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	credit_bound: assert property (@(posedge clk) disable iff (trig_reset)
		credits <= KS_CREDITS);

	addr_in_string: assert property (@(posedge clk) disable iff (trig_reset)
		step.valid |-> (step.addr < cfg_q.length));

endmodule

// ==== hdl/ks_pkg.sv ====
package ks_pkg;

	// sample and slot address widths
	localparam int KS_DATA_W = 32;
	localparam int KS_ADDR_W = 9;

	// strings shorter than this are stretched to it
	localparam int KS_MIN_LEN = 4;

	// output credits available after reset
	localparam int KS_CREDITS = 8;

	// idle cycles between the pluck edge and the first excitation step
	localparam int KS_DRAIN_CYCLES = 2;

	// right shifting galois lfsr for x^32 + x^22 + x^2 + x + 1
	localparam logic [KS_DATA_W-1:0] KS_LFSR_SEED = 32'h1D87_2B41;
	localparam logic [KS_DATA_W-1:0] KS_LFSR_TAPS = 32'h8020_0003;

	typedef enum logic [1:0]
	{
		IDLE,
		DRAIN,
		EXCITE,
		SUSTAIN
	} ks_state_e;

	// configuration sampled on the pluck edge
	typedef struct packed
	{
		logic [KS_ADDR_W-1:0] length;
		logic [3:0]           decay_shift;
	} ks_cfg_t;

	// one delay slot visit
	typedef struct packed
	{
		logic                 valid;
		logic [KS_ADDR_W-1:0] addr;
		logic                 excite;
		logic [3:0]           decay_shift;
	} ks_step_t;

	typedef struct packed
	{
		logic                        valid;
		logic signed [KS_DATA_W-1:0] data;
	} ks_sample_t;

endpackage

// ==== hdl/ks_string_top.sv ====
`timescale 1ns/1ps

module ks_string_top
	import ks_pkg::*;
(
	input  logic       clk,
	input  logic       trig_reset,
	input  logic       pluck,
	input  ks_cfg_t    cfg,
	input  logic       credit_return,
	output ks_sample_t sample
);

	ks_step_t step;
	ks_step_t step_q;

	logic signed [KS_DATA_W-1:0] rd_data;
	logic signed [KS_DATA_W-1:0] noise;

	// write back from the filter into the delay line
	logic                        wr_en;
	logic [KS_ADDR_W-1:0]        wr_addr;
	logic signed [KS_DATA_W-1:0] wr_data;

	ks_control control0 (
		.clk           (clk),
		.trig_reset    (trig_reset),
		.pluck         (pluck),
		.cfg           (cfg),
		.credit_return (credit_return),
		.step          (step)
	);

	noise_lfsr lfsr0 (
		.clk        (clk),
		.trig_reset (trig_reset),
		.step       (step),
		.noise      (noise)
	);

	delay_line line0 (
		.clk        (clk),
		.trig_reset (trig_reset),
		.step       (step),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.step_q     (step_q),
		.rd_data    (rd_data)
	);

	loss_filter filter0 (
		.clk        (clk),
		.trig_reset (trig_reset),
		.step_q     (step_q),
		.rd_data    (rd_data),
		.noise      (noise),
		.sample     (sample),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

endmodule

// ==== hdl/loss_filter.sv ====
`timescale 1ns/1ps

module loss_filter
	import ks_pkg::*;
(
	input  logic                        clk,
	input  logic                        trig_reset,
	input  ks_step_t                    step_q,
	input  logic signed [KS_DATA_W-1:0] rd_data,
	input  logic signed [KS_DATA_W-1:0] noise,
	output ks_sample_t                  sample,
	output logic                        wr_en,
	output logic [KS_ADDR_W-1:0]        wr_addr,
	output logic signed [KS_DATA_W-1:0] wr_data
);

	logic signed [KS_DATA_W-1:0] prev;
	logic signed [KS_DATA_W:0]   sum_ext;
	logic signed [KS_DATA_W-1:0] avg;
	logic signed [KS_DATA_W-1:0] damped;
	logic signed [KS_DATA_W-1:0] result;

	always_comb
	begin
		// 33 bit sum so the average cannot overflow
		sum_ext = rd_data + prev;
		avg     = sum_ext[KS_DATA_W:1];
		if (step_q.decay_shift == 4'd0)
		begin
			damped = avg;
		end
		else
		begin
			damped = avg - (avg >>> step_q.decay_shift);
		end
		result = step_q.excite ? noise : damped;
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			prev        <= '0;
			sample      <= '0;
			wr_en       <= 1'b0;
			wr_addr     <= '0;
			wr_data     <= '0;
		end
		else
		begin
			sample.valid <= step_q.valid;
			wr_en        <= step_q.valid;
			if (step_q.valid)
			begin
				prev        <= result;
				sample.data <= result;
				// same sample goes back into the slot it was read from
				wr_addr     <= step_q.addr;
				wr_data     <= result;
			end
		end
	end

endmodule

// ==== hdl/noise_lfsr.sv ====
`timescale 1ns/1ps

module noise_lfsr
	import ks_pkg::*;
(
	input  logic                        clk,
	input  logic                        trig_reset,
	input  ks_step_t                    step,
	output logic signed [KS_DATA_W-1:0] noise
);

	logic [KS_DATA_W-1:0] lfsr;

	// noise lines up with step_q out of the delay line
	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			lfsr  <= KS_LFSR_SEED;
			noise <= '0;
		end
		else if (step.valid && step.excite)
		begin
			noise <= lfsr;
			// shift right, fold the dropped bit back through the taps
			lfsr  <= (lfsr >> 1) ^ (lfsr[0] ? KS_LFSR_TAPS : '0);
		end
	end

	lfsr_nonzero: assert property (@(posedge clk) disable iff (trig_reset)
		lfsr != '0);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ks_tb simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ks_tb -f verilog.f

out=$(./obj_dir/Vks_tb)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

// ==== verification/ks_tb.sv ====
`timescale 1ns/1ps

module ks_tb
	import ks_pkg::*;
;

	logic       clk;
	logic       trig_reset;
	logic       pluck;
	ks_cfg_t    cfg;
	logic       credit_return;
	ks_sample_t sample;

	logic [31:0] lcg_state = 32'd24;
	int          cycle = 0;
	int          limit_cycles = 0;

	// length, decay and sample count of each note
	int note_len[$];
	int note_decay[$];
	int note_target[$];

	// pluck waiting to take effect in the model
	logic pend_valid = 1'b0;
	int   pend_cycle;
	int   pend_len;
	int   pend_decay;

	// reference model state
	logic signed [KS_DATA_W-1:0] m_mem [0:(2**KS_ADDR_W)-1];
	logic [KS_DATA_W-1:0]        m_lfsr = KS_LFSR_SEED;
	logic signed [KS_DATA_W-1:0] m_prev = '0;
	logic signed [KS_DATA_W-1:0] expected;
	int  m_ptr = 0;
	int  m_len = 0;
	int  m_decay = 0;
	int  m_exc_left = 0;
	logic note_active = 1'b0;
	int  notes_started = 0;
	int  note_samples = 0;

	// consumer bookkeeping
	int due_q[$];
	int hold_cnt = 0;
	int received = 0;
	int returned = 0;
	int data_errors = 0;
	int proto_errors = 0;

	ks_tb_clock clock0 (.clk(clk));

	ks_string_top dut0 (
		.clk           (clk),
		.trig_reset    (trig_reset),
		.pluck         (pluck),
		.cfg           (cfg),
		.credit_return (credit_return),
		.sample        (sample)
	);

	function automatic int next_random(input int range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % range;
	endfunction

	function automatic int clamp_length(input int len);
		return (len < KS_MIN_LEN) ? KS_MIN_LEN : len;
	endfunction

	task automatic start_model_note();
		m_len = pend_len;
		m_decay = pend_decay;
		m_exc_left = pend_len;
		m_ptr = 0;
		note_active = 1'b1;
		note_samples = 0;
		notes_started++;
		pend_valid = 1'b0;
	endtask

	// next sample of the string, following the averaging and decay rules
	task automatic model_step(output logic signed [KS_DATA_W-1:0] val);
		logic signed [KS_DATA_W:0]   sum;
		logic signed [KS_DATA_W-1:0] a;
		logic                        out_bit;
		if (m_exc_left > 0)
		begin
			val = m_lfsr;
			out_bit = m_lfsr[0];
			m_lfsr = m_lfsr >> 1;
			if (out_bit)
				m_lfsr = m_lfsr ^ KS_LFSR_TAPS;
			m_exc_left--;
		end
		else
		begin
			sum = $signed({m_mem[m_ptr][KS_DATA_W-1], m_mem[m_ptr]})
				+ $signed({m_prev[KS_DATA_W-1], m_prev});
			a = sum[KS_DATA_W:1];
			if (m_decay == 0)
				val = a;
			else
				val = a - (a >>> m_decay);
		end
		m_mem[m_ptr] = val;
		m_prev = val;
		m_ptr = (m_ptr == m_len - 1) ? 0 : m_ptr + 1;
	endtask

	task automatic pluck_note(input int len, input int decay);
		@(posedge clk);
		cfg <= '{length: KS_ADDR_W'(len), decay_shift: 4'(decay)};
		pluck <= 1'b1;
		#1;
		pend_len = clamp_length(len);
		pend_decay = decay;
		pend_cycle = cycle;
		pend_valid = 1'b1;
		@(posedge clk);
		pluck <= 1'b0;
	endtask

	task automatic report_counts();
		$display("samples %0d, data errors %0d, protocol errors %0d",
			received, data_errors, proto_errors);
	endtask

	// consumer returns credits late and sometimes holds them all
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (trig_reset)
			credit_return <= 1'b0;
		else if (hold_cnt != 0)
		begin
			hold_cnt <= hold_cnt - 1;
			credit_return <= 1'b0;
		end
		else if (next_random(20) == 0)
		begin
			hold_cnt <= 8 + next_random(32);
			credit_return <= 1'b0;
		end
		else if (due_q.size() != 0 && due_q[0] <= cycle)
		begin
			void'(due_q.pop_front());
			credit_return <= 1'b1;
			returned++;
		end
		else
			credit_return <= 1'b0;
	end

	// outputs are read mid cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (!trig_reset && sample.valid)
		begin
			// old samples end by pend_cycle+2 and new ones start at pend_cycle+5
			if (pend_valid && cycle >= pend_cycle + 3)
			begin
				assert (cycle >= pend_cycle + KS_DRAIN_CYCLES + 3)
				else
				begin
					proto_errors++;
					$display("a sample came out during the drain at cycle %0d", cycle);
				end
				start_model_note();
			end
			received++;
			due_q.push_back(cycle + next_random(7));
			assert (received - returned <= KS_CREDITS)
			else
			begin
				proto_errors++;
				$display("more samples outstanding than credits allow at cycle %0d", cycle);
			end
			assert (note_active)
			else
			begin
				proto_errors++;
				$display("sample.valid was raised before any pluck at cycle %0d", cycle);
			end
			if (note_active)
			begin
				model_step(expected);
				note_samples++;
				assert (sample.data == expected)
				else
				begin
					data_errors++;
					$display("ERROR: sample.data note %0d sample %0d expected %h actual %h",
						notes_started, note_samples, expected, sample.data);
				end
			end
		end
	end

	initial
	begin
		int total;
		int target;
		trig_reset = 1'b1;
		pluck = 1'b0;
		cfg = '0;
		credit_return = 1'b0;

		// short, minimum, random and longest strings
		note_len = '{2, 4, next_random(512), 511, next_random(512), next_random(64)};
		note_decay = '{0, 1, next_random(16), next_random(16), 0, next_random(16)};
		total = 0;
		foreach (note_len[i])
		begin
			note_target.push_back(clamp_length(note_len[i]) * 3 + next_random(40));
			total += note_target[i];
		end
		limit_cycles = total * 10 + 2000;

		repeat (4) @(posedge clk);
		trig_reset <= 1'b0;

		// nothing may come out before the first pluck
		repeat (30) @(posedge clk);

		foreach (note_len[i])
		begin
			pluck_note(note_len[i], note_decay[i]);
			target = note_target[i];
			wait (notes_started == i + 1 && note_samples >= target);
		end

		repeat (20) @(posedge clk);
		report_counts();
		if (data_errors == 0 && proto_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles, the expected samples did not all arrive",
			limit_cycles);
		report_counts();
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== verification/ks_tb_clock.sv ====
`timescale 1ns/1ps

module ks_tb_clock
(
	output logic clk
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

// ==== verilog.f ====
hdl/ks_pkg.sv
hdl/ks_control.sv
hdl/noise_lfsr.sv
hdl/delay_line.sv
hdl/loss_filter.sv
hdl/ks_string_top.sv
verification/ks_tb_clock.sv
verification/ks_tb.sv
